// ==== files.f ====
+incdir+include
verilog/dzPkg.sv
verilog/dzUartTx.sv
verilog/dzUartRx.sv
verilog/dzSilo.sv
verilog/dzRegs.sv
verilog/dz11.sv
test/dzTb.sv

// ==== include/dzRegs.svh ====
// DZ11 register field positions

`ifndef DZREGS_SVH
`define DZREGS_SVH

// CSR fields
`define dzCSR_MSE    0
`define dzCSR_RDONE  7
`define dzCSR_TLINE  10:8
`define dzCSR_SOVF   14
`define dzCSR_TRDY   15

// RBUF fields
`define dzRBUF_CHAR  7:0
`define dzRBUF_LINE  10:8
`define dzRBUF_VALID 15

// TCR line enables
`define dzTCR_LINE   7:0

`endif

// ==== test/dzTb.sv ====
// DZ11 loopback testbench
`timescale 1ns/1ps

`include "dzRegs.svh"

module dzTb;

   import dzPkg::*;

   localparam int CLKS_PER_BIT = 16;
   localparam int SILO_DEPTH   = 16;
   localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
   // Handshake wait in clocks
   localparam int WAIT_LIMIT   = 64;
   // Poll limit in register reads
   localparam int POLL_LIMIT   = 200;
   localparam int NUM_ROWS     = 8;
   localparam int OVF_CHARS    = 24;

   // TCR, MSE, expected TLINE and TRDY, loopback expected
   typedef struct packed {
      logic [7:0] tcr;
      logic       mse;
      logic [2:0] tLine;
      logic       tRdy;
      logic       sends;
   } rowT;

   logic                  clk;
   logic                  rstN;
   logic [AXI_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [AXI_DATA_W-1:0] wdata;
   logic [3:0]            wstrb;
   logic                  wvalid;
   logic                  wready;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;
   logic [AXI_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic [AXI_DATA_W-1:0] rdata;
   logic [1:0]            rresp;
   logic                  rvalid;
   logic                  rready;
   logic [NUM_LINES-1:0]  txd;
   logic [NUM_LINES-1:0]  rxd;
   rowT                   rows [NUM_ROWS];

   // Every line looped back onto itself
   assign rxd = txd;

   dz11 #(.CLKS_PER_BIT(CLKS_PER_BIT), .SILO_DEPTH(SILO_DEPTH)) i_dz11 (
      .clk, .rstN,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .txd, .rxd
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic stopWithFailure();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         stopWithFailure();
      end
   endtask

   task automatic timeoutFail(input string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      stopWithFailure();
   endtask

   //////////////////////////////
   // AXI4-Lite master
   //////////////////////////////

   // Ready and valid sampled on the rising edge before the DUT updates
   task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
      int cnt;
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      cnt = 0;
      do
      begin
         @(posedge clk);
         cnt++;
         if (cnt > WAIT_LIMIT)
            timeoutFail("awready and wready");
      end
      while (!(awready && wready));
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      cnt = 0;
      do
      begin
         @(posedge clk);
         cnt++;
         if (cnt > WAIT_LIMIT)
            timeoutFail("bvalid");
      end
      while (!bvalid);
      checkEq("bresp", bresp, 2'b00);
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
      int cnt;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      cnt = 0;
      do
      begin
         @(posedge clk);
         cnt++;
         if (cnt > WAIT_LIMIT)
            timeoutFail("arready");
      end
      while (!arready);
      @(negedge clk);
      arvalid = 1'b0;
      rready  = 1'b1;
      cnt = 0;
      do
      begin
         @(posedge clk);
         cnt++;
         if (cnt > WAIT_LIMIT)
            timeoutFail("rvalid");
      end
      while (!rvalid);
      data = rdata;
      checkEq("rresp", rresp, 2'b00);
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic readCheck(input logic [3:0] addr, input string name, input logic [31:0] exp);
      logic [31:0] data;
      axiRead(addr, data);
      checkEq(name, data, exp);
   endtask

   //////////////////////////////
   // Register polling
   //////////////////////////////

   task automatic pollRbuf(output logic [31:0] data);
      int tries;
      tries = 0;
      axiRead(REG_RBUF, data);
      while (!data[`dzRBUF_VALID])
      begin
         tries++;
         if (tries > POLL_LIMIT)
            timeoutFail("a valid RBUF entry");
         axiRead(REG_RBUF, data);
      end
   endtask

   task automatic waitTrdy(output lineT line);
      logic [31:0] data;
      int          tries;
      tries = 0;
      axiRead(REG_CSR, data);
      while (!data[`dzCSR_TRDY])
      begin
         tries++;
         if (tries > POLL_LIMIT)
            timeoutFail("TRDY in CSR");
         axiRead(REG_CSR, data);
      end
      line = data[`dzCSR_TLINE];
   endtask

   // Line's transmitter idle again once the scanner offers it
   task automatic waitLineIdle(input lineT line);
      logic [31:0] data;
      int          tries;
      tries = 0;
      axiRead(REG_CSR, data);
      while (!(data[`dzCSR_TRDY] && data[`dzCSR_TLINE] == line))
      begin
         tries++;
         if (tries > POLL_LIMIT)
            timeoutFail("the transmitter to go idle");
         axiRead(REG_CSR, data);
      end
   endtask

   // Two frame times of quiet lines then an empty silo
   task automatic checkQuiet();
      for (int c = 0; c < 2 * FRAME_CLKS; c++)
      begin
         @(negedge clk);
         checkEq("txd", txd, {NUM_LINES{1'b1}});
      end
      readCheck(REG_RBUF, "RBUF after dropped TDR", 32'h0);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      int          seed;
      logic [31:0] rd;
      charT        ch;
      lineT        line;
      charT        sentChar [NUM_LINES];
      logic [NUM_LINES-1:0] seen;
      charT        ovfChar [OVF_CHARS];
      lineT        ovfLine [OVF_CHARS];
      logic        ovfUsed [OVF_CHARS];
      logic        hit;

      seed = 32'he2689b40;
      void'($urandom(seed));

      rstN    = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hF;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;

      // TCR, MSE, TLINE, TRDY, sends
      rows[0] = '{8'h00, 1'b0, 3'd0, 1'b0, 1'b0};
      rows[1] = '{8'h01, 1'b1, 3'd0, 1'b1, 1'b1};
      rows[2] = '{8'h0C, 1'b1, 3'd2, 1'b1, 1'b1};
      rows[3] = '{8'h80, 1'b1, 3'd7, 1'b1, 1'b1};
      // Scanner still names a line with MSE clear
      rows[4] = '{8'hA0, 1'b0, 3'd5, 1'b0, 1'b0};
      rows[5] = '{8'h00, 1'b1, 3'd0, 1'b0, 1'b0};
      rows[6] = '{8'h30, 1'b1, 3'd4, 1'b1, 1'b1};
      rows[7] = '{8'h42, 1'b1, 3'd1, 1'b1, 1'b1};

      repeat (4) @(negedge clk);
      rstN = 1'b1;

      // Reset values
      readCheck(REG_CSR, "CSR after reset", 32'h0);
      readCheck(REG_TCR, "TCR after reset", 32'h0);
      readCheck(REG_RBUF, "RBUF after reset", 32'h0);

      // Scanner rows with loopback where TRDY
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         axiWrite(REG_TCR, 32'(rows[r].tcr));
         axiWrite(REG_CSR, 32'(rows[r].mse));
         readCheck(REG_TCR, "TCR", 32'(rows[r].tcr));
         axiRead(REG_CSR, rd);
         checkEq("CSR.MSE", rd[`dzCSR_MSE], rows[r].mse);
         checkEq("CSR.TLINE", rd[`dzCSR_TLINE], rows[r].tLine);
         checkEq("CSR.TRDY", rd[`dzCSR_TRDY], rows[r].tRdy);
         ch = charT'($urandom());
         axiWrite(REG_TDR, 32'(ch));
         if (rows[r].sends)
         begin
            pollRbuf(rd);
            checkEq("RBUF.CHAR", rd[`dzRBUF_CHAR], ch);
            checkEq("RBUF.LINE", rd[`dzRBUF_LINE], rows[r].tLine);
            waitLineIdle(rows[r].tLine);
         end
         else
            checkQuiet();
      end

      // One character per line in line order
      axiWrite(REG_TCR, 32'hFF);
      axiWrite(REG_CSR, 32'h1);
      for (int k = 0; k < NUM_LINES; k++)
      begin
         waitTrdy(line);
         checkEq("CSR.TLINE", line, k);
         ch = charT'($urandom());
         sentChar[line] = ch;
         axiWrite(REG_TDR, 32'(ch));
      end
      seen = '0;
      for (int k = 0; k < NUM_LINES; k++)
      begin
         pollRbuf(rd);
         line = rd[`dzRBUF_LINE];
         checkEq("RBUF.LINE repeated", seen[line], 1'b0);
         seen[line] = 1'b1;
         checkEq("RBUF.CHAR", rd[`dzRBUF_CHAR], sentChar[line]);
      end
      readCheck(REG_RBUF, "RBUF after eight entries", 32'h0);

      // Three waves of eight into a silo of sixteen
      // Lines free up in load order so each wave runs 0 to 7
      for (int k = 0; k < OVF_CHARS; k++)
      begin
         waitTrdy(line);
         checkEq("CSR.TLINE", line, k % NUM_LINES);
         ch = charT'($urandom());
         ovfLine[k] = lineT'(k % NUM_LINES);
         ovfChar[k] = ch;
         ovfUsed[k] = 1'b0;
         axiWrite(REG_TDR, 32'(ch));
      end
      // Last frames land within one frame time
      repeat (2 * FRAME_CLKS) @(negedge clk);
      axiRead(REG_CSR, rd);
      checkEq("CSR.SOVF", rd[`dzCSR_SOVF], 1'b1);
      checkEq("CSR.RDONE", rd[`dzCSR_RDONE], 1'b1);
      for (int k = 0; k < SILO_DEPTH; k++)
      begin
         axiRead(REG_RBUF, rd);
         checkEq("RBUF.VALID", rd[`dzRBUF_VALID], 1'b1);
         hit = 1'b0;
         for (int j = 0; j < OVF_CHARS; j++)
         begin
            if (!hit && !ovfUsed[j] && ovfLine[j] == rd[`dzRBUF_LINE] &&
                ovfChar[j] == rd[`dzRBUF_CHAR])
            begin
               hit = 1'b1;
               ovfUsed[j] = 1'b1;
            end
         end
         checkEq("RBUF entry among sent", hit, 1'b1);
      end
      readCheck(REG_RBUF, "RBUF after silo drained", 32'h0);
      axiRead(REG_CSR, rd);
      checkEq("CSR.SOVF after read", rd[`dzCSR_SOVF], 1'b0);
      checkEq("CSR.RDONE after drain", rd[`dzCSR_RDONE], 1'b0);

      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== verilog/dz11.sv ====
// DZ11 eight-line serial multiplexer
`timescale 1ns/1ps

module dz11 #(
   parameter int CLKS_PER_BIT = 16,
   parameter int SILO_DEPTH   = 16
) (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic [dzPkg::AXI_ADDR_W-1:0]      awaddr,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [dzPkg::AXI_DATA_W-1:0]      wdata,
   input  logic [dzPkg::AXI_DATA_W/8-1:0]    wstrb,
   input  logic                              wvalid,
   output logic                              wready,
   output logic [1:0]                        bresp,
   output logic                              bvalid,
   input  logic                              bready,
   input  logic [dzPkg::AXI_ADDR_W-1:0]      araddr,
   input  logic                              arvalid,
   output logic                              arready,
   output logic [dzPkg::AXI_DATA_W-1:0]      rdata,
   output logic [1:0]                        rresp,
   output logic                              rvalid,
   input  logic                              rready,
   output logic [dzPkg::NUM_LINES-1:0]       txd,
   input  logic [dzPkg::NUM_LINES-1:0]       rxd
);

   import dzPkg::*;

   logic [NUM_LINES-1:0]  txLoad;
   logic [NUM_LINES-1:0]  txBusy;
   charT                  txData;
   logic [NUM_LINES-1:0]  rxValid;
   charT [NUM_LINES-1:0]  rxChar;
   logic [NUM_LINES-1:0]  rxAck;
   logic                  siloEmpty;
   siloEntryT             siloHead;
   logic                  siloOverflow;
   logic                  siloPop;

   // Register file and scanner
   dzRegs i_dzRegs (
      .clk, .rstN,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .txBusy, .txLoad, .txData,
      .siloEmpty, .siloHead, .siloOverflow, .siloPop
   );

   dzSilo #(.SILO_DEPTH(SILO_DEPTH)) i_dzSilo (
      .clk, .rstN,
      .rxValid, .rxChar, .rxAck,
      .pop(siloPop), .empty(siloEmpty), .head(siloHead), .overflow(siloOverflow)
   );

   // Transmitters share one data bus
   for (genvar i = 0; i < NUM_LINES; i++) begin : g_tx
      dzUartTx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_dzUartTx (
         .clk, .rstN, .load(txLoad[i]), .data(txData), .busy(txBusy[i]), .txd(txd[i])
      );
   end

   for (genvar i = 0; i < NUM_LINES; i++) begin : g_rx
      dzUartRx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_dzUartRx (
         .clk, .rstN, .rxd(rxd[i]), .ack(rxAck[i]), .valid(rxValid[i]), .data(rxChar[i])
      );
   end

endmodule

// ==== verilog/dzPkg.sv ====
// DZ11 shared types and widths

package dzPkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   // Eight serial lines
   localparam int NUM_LINES = 8;
   localparam int LINE_W = $clog2(NUM_LINES);
   localparam int CHAR_W = 8;

   // AXI4-Lite slave widths
   localparam int AXI_DATA_W = 32;
   localparam int AXI_ADDR_W = 4;

   //////////////////////////////
   // Types
   //////////////////////////////

   typedef logic [LINE_W-1:0] lineT;
   typedef logic [CHAR_W-1:0] charT;

   // One received character tagged with its line
   typedef struct packed {
      lineT line;
      charT chr;
   } siloEntryT;

   // Word offsets of the register file
   typedef enum logic [AXI_ADDR_W-1:0] {
      REG_CSR  = 4'h0,
      REG_RBUF = 4'h4,
      REG_TCR  = 4'h8,
      REG_TDR  = 4'hC
   } regAddrT;

endpackage

// ==== verilog/dzRegs.sv ====
// DZ11 register block, AXI4-Lite slave
`timescale 1ns/1ps

`include "dzRegs.svh"

module dzRegs (
   input  logic                               clk,
   input  logic                               rstN,
   // AXI4-Lite slave
   input  logic [dzPkg::AXI_ADDR_W-1:0]       awaddr,
   input  logic                               awvalid,
   output logic                               awready,
   input  logic [dzPkg::AXI_DATA_W-1:0]       wdata,
   input  logic [dzPkg::AXI_DATA_W/8-1:0]     wstrb,
   input  logic                               wvalid,
   output logic                               wready,
   output logic [1:0]                         bresp,
   output logic                               bvalid,
   input  logic                               bready,
   input  logic [dzPkg::AXI_ADDR_W-1:0]       araddr,
   input  logic                               arvalid,
   output logic                               arready,
   output logic [dzPkg::AXI_DATA_W-1:0]       rdata,
   output logic [1:0]                         rresp,
   output logic                               rvalid,
   input  logic                               rready,
   // Transmitters
   input  logic [dzPkg::NUM_LINES-1:0]        txBusy,
   output logic [dzPkg::NUM_LINES-1:0]        txLoad,
   output dzPkg::charT                        txData,
   // Silo
   input  logic                               siloEmpty,
   input  dzPkg::siloEntryT                   siloHead,
   input  logic                               siloOverflow,
   output logic                               siloPop
);

   import dzPkg::*;

   regAddrT                wrAddr;
   regAddrT                rdAddr;
   logic                   wrAccept;
   logic                   rdAccept;
   logic                   mse;
   logic [NUM_LINES-1:0]   tcr;
   logic                   sovf;
   lineT                   tLine;
   logic                   tRdy;
   logic [AXI_DATA_W-1:0]  rdNext;

   //////////////////////////////
   // AXI handshakes
   //////////////////////////////

   assign wrAddr   = regAddrT'(awaddr);
   assign rdAddr   = regAddrT'(araddr);
   // Address and data taken together, one at a time
   assign wrAccept = awvalid && wvalid && !bvalid;
   assign rdAccept = arvalid && !rvalid;
   assign awready  = wrAccept;
   assign wready   = wrAccept;
   assign arready  = rdAccept;
   assign bresp    = 2'b00;
   assign rresp    = 2'b00;

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         if (wrAccept)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (rdAccept)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   //////////////////////////////
   // Control registers
   //////////////////////////////

   // Full-word writes only, wstrb lanes not decoded
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         mse  <= 1'b0;
         tcr  <= '0;
         sovf <= 1'b0;
      end
      else
      begin
         if (wrAccept && wrAddr == REG_CSR)
            mse <= wdata[`dzCSR_MSE];
         if (wrAccept && wrAddr == REG_TCR)
            tcr <= wdata[`dzTCR_LINE];
         // Sticky; a new overflow beats the read clear
         if (siloOverflow)
            sovf <= 1'b1;
         else if (rdAccept && rdAddr == REG_CSR)
            sovf <= 1'b0;
      end
   end

   //////////////////////////////
   // Transmit scanner and TDR
   //////////////////////////////

   // Lowest enabled line with an idle transmitter
   always_comb
   begin
      logic found;
      found = 1'b0;
      tLine = '0;
      for (int i = 0; i < NUM_LINES; i++)
      begin
         if (!found && tcr[i] && !txBusy[i])
         begin
            found = 1'b1;
            tLine = lineT'(i);
         end
      end
      tRdy = mse && found;
   end

   // TDR write without TRDY is dropped
   assign txLoad = (wrAccept && wrAddr == REG_TDR && tRdy) ?
                   (NUM_LINES'(1) << tLine) : '0;
   assign txData = wdata[7:0];

   //////////////////////////////
   // Read mux
   //////////////////////////////

   assign siloPop = rdAccept && rdAddr == REG_RBUF && !siloEmpty;

   always_comb
   begin
      rdNext = '0;
      case (rdAddr)
         REG_CSR:
         begin
            rdNext[`dzCSR_MSE]   = mse;
            rdNext[`dzCSR_RDONE] = !siloEmpty;
            rdNext[`dzCSR_TLINE] = tLine;
            rdNext[`dzCSR_SOVF]  = sovf;
            rdNext[`dzCSR_TRDY]  = tRdy;
         end
         REG_RBUF:
            if (!siloEmpty)
            begin
               rdNext[`dzRBUF_CHAR]  = siloHead.chr;
               rdNext[`dzRBUF_LINE]  = siloHead.line;
               rdNext[`dzRBUF_VALID] = 1'b1;
            end
         REG_TCR:
            rdNext[`dzTCR_LINE] = tcr;
         // TDR is write-only, others unmapped
         default:
            rdNext = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rdAccept)
         rdata <= rdNext;
   end

endmodule

// ==== verilog/dzSilo.sv ====
// DZ11 receive silo with round-robin arbiter
`timescale 1ns/1ps

module dzSilo #(
   parameter int SILO_DEPTH = 16
) (
   input  logic                                    clk,
   input  logic                                    rstN,
   input  logic        [dzPkg::NUM_LINES-1:0]      rxValid,
   input  dzPkg::charT [dzPkg::NUM_LINES-1:0]      rxChar,
   output logic        [dzPkg::NUM_LINES-1:0]      rxAck,
   input  logic                                    pop,
   output logic                                    empty,
   output dzPkg::siloEntryT                        head,
   output logic                                    overflow
);

   import dzPkg::*;

   localparam int PTR_W = $clog2(SILO_DEPTH);

   siloEntryT          mem [SILO_DEPTH];
   logic [PTR_W-1:0]   wrPtr;
   logic [PTR_W-1:0]   rdPtr;
   logic [PTR_W:0]     count;
   lineT               lastGrant;
   lineT               grantLine;
   logic               grantValid;
   logic               full;
   logic               push;
   logic               doPop;

   //////////////////////////////
   // Round-robin arbiter
   //////////////////////////////

   // Search starts just past the last winner
   always_comb
   begin
      lineT idx;
      grantValid = 1'b0;
      grantLine  = '0;
      for (int k = 1; k <= NUM_LINES; k++)
      begin
         idx = lineT'(lastGrant + lineT'(k));
         if (!grantValid && rxValid[idx])
         begin
            grantValid = 1'b1;
            grantLine  = idx;
         end
      end
   end

   assign rxAck = grantValid ? (NUM_LINES'(1) << grantLine) : '0;

   //////////////////////////////
   // Circular buffer
   //////////////////////////////

   assign full  = (count == (PTR_W + 1)'(SILO_DEPTH));
   assign empty = (count == '0);
   assign push  = grantValid && !full;
   assign doPop = pop && !empty;
   assign head  = mem[rdPtr];

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         wrPtr     <= '0;
         rdPtr     <= '0;
         count     <= '0;
         overflow  <= 1'b0;
         // Line 0 wins first
         lastGrant <= lineT'(NUM_LINES - 1);
      end
      else
      begin
         // Granted character lost when full
         overflow <= grantValid && full;
         if (grantValid)
            lastGrant <= grantLine;
         if (push)
            wrPtr <= wrPtr + 1'b1;
         if (doPop)
            rdPtr <= rdPtr + 1'b1;
         if (push && !doPop)
            count <= count + 1'b1;
         else if (doPop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wrPtr] <= '{line: grantLine, chr: rxChar[grantLine]};
   end

endmodule

// ==== verilog/dzUartRx.sv ====
// DZ11 line receiver, 8N1
`timescale 1ns/1ps

module dzUartRx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic        clk,
   input  logic        rstN,
   input  logic        rxd,
   input  logic        ack,
   output logic        valid,
   output dzPkg::charT data
);

   import dzPkg::*;

   localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateT;

   rxStateT           state;
   logic              rxMeta;
   logic              rxSync;
   logic [BAUD_W-1:0] baudCnt;
   logic [2:0]        bitCnt;
   charT              shiftReg;
   logic              halfBit;
   logic              fullBit;

   assign halfBit = (baudCnt == BAUD_W'(CLKS_PER_BIT / 2 - 1));
   assign fullBit = (baudCnt == BAUD_W'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         rxMeta  <= 1'b1;
         rxSync  <= 1'b1;
         state   <= RX_IDLE;
         baudCnt <= '0;
         bitCnt  <= '0;
         valid   <= 1'b0;
      end
      else
      begin
         // Two-flop synchronizer
         rxMeta <= rxd;
         rxSync <= rxMeta;
         baudCnt <= baudCnt + 1'b1;
         // Silo took the character
         if (ack)
            valid <= 1'b0;
         case (state)
            RX_IDLE:
            begin
               baudCnt <= '0;
               if (!rxSync)
                  state <= RX_START;
            end
            RX_START:
               // Mid start bit, reject glitches
               if (halfBit)
               begin
                  baudCnt <= '0;
                  bitCnt  <= '0;
                  state   <= rxSync ? RX_IDLE : RX_DATA;
               end
            RX_DATA:
               if (fullBit)
               begin
                  baudCnt <= '0;
                  bitCnt  <= bitCnt + 3'd1;
                  if (bitCnt == 3'd7)
                     state <= RX_STOP;
               end
            default:
               // Mid stop bit; a framing error drops the character
               if (fullBit)
               begin
                  state <= RX_IDLE;
                  if (rxSync)
                     valid <= 1'b1;
               end
         endcase
      end
   end

   // Payload path, LSB arrives first
   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && fullBit)
         shiftReg <= {rxSync, shiftReg[7:1]};
      // Newer character replaces a held one
      if (state == RX_STOP && fullBit && rxSync)
         data <= shiftReg;
   end

endmodule

// ==== verilog/dzUartTx.sv ====
// DZ11 line transmitter, 8N1
`timescale 1ns/1ps

module dzUartTx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic        clk,
   input  logic        rstN,
   input  logic        load,
   input  dzPkg::charT data,
   output logic        busy,
   output logic        txd
);

   localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);

   logic [BAUD_W-1:0] baudCnt;
   logic [3:0]        bitCnt;
   // Stop, data LSB first, start
   logic [9:0]        shiftReg;
   logic              bitEnd;

   // Last clock of the current bit
   assign bitEnd = (baudCnt == BAUD_W'(CLKS_PER_BIT - 1));

   // Line idles high since shiftReg fills with ones
   assign txd = shiftReg[0];

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         busy     <= 1'b0;
         baudCnt  <= '0;
         bitCnt   <= '0;
         shiftReg <= '1;
      end
      else if (!busy)
      begin
         // Load only accepted while idle
         if (load)
         begin
            shiftReg <= {1'b1, data, 1'b0};
            busy     <= 1'b1;
            baudCnt  <= '0;
            bitCnt   <= '0;
         end
      end
      else if (bitEnd)
      begin
         baudCnt  <= '0;
         shiftReg <= {1'b1, shiftReg[9:1]};
         // Ten bits sent, stop bit done
         if (bitCnt == 4'd9)
            busy <= 1'b0;
         else
            bitCnt <= bitCnt + 4'd1;
      end
      else
         baudCnt <= baudCnt + 1'b1;
   end

endmodule
